// ==== dmix_pkg.sv ====
package dmix_pkg;

    // mixer geometry
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 2;   // enough bits to name every lane

    // sample and gain formats
    localparam int SAMPLE_W  = 24;  // signed pcm
    localparam int VOL_W     = 16;  // gain = vol / 65536

    // i2s framing
    localparam int SLOT_W    = 32;  // bit slots per channel
    localparam int BCK_HALF  = 2;   // clocks per half bck period

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef logic [VOL_W-1:0] vol_t;

    // one stereo frame, left in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // input stream word, tag picks the destination lane
    typedef struct packed {
        logic [LANE_W-1:0] lane;
        stereo_t           frame;
    } tagged_frame_t;

    typedef enum logic [1:0] {
        TX_IDLE,    // waiting for the first mixed frame
        TX_LEFT,    // lrck low
        TX_RIGHT    // lrck high
    } tx_state_e;

endpackage

// ==== dmix_in_router.sv ====
`timescale 1ns/1ps

module dmix_in_router (
    input  logic                           clk245760,
    input  logic                           rst_n_i,
    input  dmix_pkg::tagged_frame_t        in_frame_i,
    input  logic                           in_valid_i,
    output logic                           in_ready_o,
    output dmix_pkg::stereo_t              lane_frame_o,
    output logic [dmix_pkg::NUM_LANES-1:0] lane_valid_o,
    input  logic [dmix_pkg::NUM_LANES-1:0] lane_ready_i,
    output logic                           bad_tag_o
);

    dmix_pkg::tagged_frame_t frame_q;
    logic                    full_q;
    logic                    up_q;      // low during the first cycle out of reset
    logic                    bad_q;
    logic                    tag_ok;
    logic                    drain;
    logic                    accept;

    assign tag_ok = int'(frame_q.lane) < dmix_pkg::NUM_LANES;

    // one-hot valid toward the addressed lane
    always_comb begin
        lane_valid_o = '0;
        if (full_q && tag_ok) begin
            lane_valid_o[frame_q.lane] = 1'b1;
        end
    end

    // bad tags leave without a handshake
    assign drain        = full_q && (!tag_ok || lane_ready_i[frame_q.lane]);
    assign in_ready_o   = up_q && (!full_q || drain);
    assign accept       = in_valid_i && in_ready_o;
    assign lane_frame_o = frame_q.frame;
    assign bad_tag_o    = bad_q;

    always_ff @(posedge clk245760) begin
        if (!rst_n_i) begin
            up_q   <= 1'b0;
            full_q <= 1'b0;
            bad_q  <= 1'b0;
        end else begin
            up_q <= 1'b1;
            if (accept) begin
                full_q <= 1'b1;
            end else if (drain) begin
                full_q <= 1'b0;
            end
            if (full_q && !tag_ok) begin
                bad_q <= 1'b1;  // sticky
            end
        end
    end

    always_ff @(posedge clk245760) begin
        if (accept) begin
            frame_q <= in_frame_i;
        end
    end

endmodule

// ==== dmix_lane.sv ====
`timescale 1ns/1ps

module dmix_lane (
    input  logic              clk245760,
    input  logic              rst_n_i,
    input  dmix_pkg::vol_t    vol_i,
    input  dmix_pkg::stereo_t in_frame_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output dmix_pkg::stereo_t out_frame_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    // full product of a signed sample and a zero-extended volume
    typedef logic signed [dmix_pkg::SAMPLE_W+dmix_pkg::VOL_W:0] prod_t;

    prod_t                           prod_l_q;
    prod_t                           prod_r_q;
    dmix_pkg::stereo_t               out_q;
    logic                            s1_q;
    logic                            s2_q;
    logic                            s1_adv;
    logic                            s2_adv;
    logic signed [dmix_pkg::VOL_W:0] gain;

    assign gain = $signed({1'b0, vol_i});

    // a stage moves when the next one is empty or draining
    assign s2_adv = !s2_q || out_ready_i;
    assign s1_adv = !s1_q || s2_adv;

    assign in_ready_o  = s1_adv;
    assign out_valid_o = s2_q;
    assign out_frame_o = out_q;

    always_ff @(posedge clk245760) begin
        if (!rst_n_i) begin
            s1_q <= 1'b0;
            s2_q <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_q <= in_valid_i;
            end
            if (s2_adv) begin
                s2_q <= s1_q;
            end
        end
    end

    // stage 1 multiply
    always_ff @(posedge clk245760) begin
        if (s1_adv && in_valid_i) begin
            prod_l_q <= in_frame_i.left * gain;
            prod_r_q <= in_frame_i.right * gain;
        end
    end

    // stage 2 drops the 16 fraction bits, result always fits a sample
    always_ff @(posedge clk245760) begin
        if (s2_adv && s1_q) begin
            out_q.left  <= dmix_pkg::sample_t'(prod_l_q >>> dmix_pkg::VOL_W);
            out_q.right <= dmix_pkg::sample_t'(prod_r_q >>> dmix_pkg::VOL_W);
        end
    end

endmodule

// ==== dmix_mixer.sv ====
`timescale 1ns/1ps

module dmix_mixer (
    input  logic                                        clk245760,
    input  logic                                        rst_n_i,
    input  dmix_pkg::stereo_t [dmix_pkg::NUM_LANES-1:0] lane_frame_i,
    input  logic [dmix_pkg::NUM_LANES-1:0]              lane_valid_i,
    output logic                                        lane_ready_o,
    output dmix_pkg::stereo_t                           mix_frame_o,
    output logic                                        mix_valid_o,
    input  logic                                        mix_ready_i
);

    // sum of all lanes plus one spare bit of headroom
    typedef logic signed [dmix_pkg::SAMPLE_W+dmix_pkg::LANE_W:0] acc_t;

    acc_t              sum_l;
    acc_t              sum_r;
    dmix_pkg::stereo_t mix_q;
    logic              valid_q;
    logic              all_valid;
    logic              out_free;

    // clamp to 24-bit signed when the bits above the sample msb disagree
    function automatic dmix_pkg::sample_t saturate(input acc_t a);
        logic [dmix_pkg::LANE_W+1:0] top;
        top = a[$bits(acc_t)-1:dmix_pkg::SAMPLE_W-1];
        if (top == '0 || top == '1) begin
            return a[dmix_pkg::SAMPLE_W-1:0];
        end else if (a[$bits(acc_t)-1]) begin
            return {1'b1, {(dmix_pkg::SAMPLE_W-1){1'b0}}};     // 0x800000
        end else begin
            return {1'b0, {(dmix_pkg::SAMPLE_W-1){1'b1}}};     // 0x7fffff
        end
    endfunction

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
            sum_l = sum_l + $signed(lane_frame_i[i].left);
            sum_r = sum_r + $signed(lane_frame_i[i].right);
        end
    end

    // all lanes hand over together
    assign all_valid    = &lane_valid_i;
    assign out_free     = !valid_q || mix_ready_i;
    assign lane_ready_o = all_valid && out_free;

    assign mix_frame_o = mix_q;
    assign mix_valid_o = valid_q;

    always_ff @(posedge clk245760) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (lane_ready_o) begin
            valid_q <= 1'b1;
        end else if (mix_ready_i) begin
            valid_q <= 1'b0;    // taken by the transmitter
        end
    end

    always_ff @(posedge clk245760) begin
        if (lane_ready_o) begin
            mix_q.left  <= saturate(sum_l);
            mix_q.right <= saturate(sum_r);
        end
    end

endmodule

// ==== dmix_i2s_tx.sv ====
`timescale 1ns/1ps

module dmix_i2s_tx (
    input  logic              clk245760,
    input  logic              rst_n_i,
    input  dmix_pkg::stereo_t frame_i,
    input  logic              valid_i,
    output logic              ready_o,
    output logic              dac_bck_o,
    output logic              dac_lrck_o,
    output logic              dac_data_o,
    output logic              underrun_o
);

    logic [$clog2(2*dmix_pkg::BCK_HALF)-1:0] div_q;   // clock phase inside one bit
    logic [$clog2(2*dmix_pkg::SLOT_W)-1:0]   bit_q;   // slot currently on the line
    logic [2*dmix_pkg::SLOT_W-1:0]           shift_q;
    logic [2*dmix_pkg::SLOT_W-1:0]           load_word;
    dmix_pkg::tx_state_e                     state_q;
    logic                                    bck_q;
    logic                                    lrck_q;
    logic                                    data_q;
    logic                                    underrun_q;
    logic                                    bit_end;
    logic                                    frame_end;
    logic                                    start;

    assign bit_end   = div_q == (2*dmix_pkg::BCK_HALF-1);
    assign frame_end = bit_end && bit_q == (2*dmix_pkg::SLOT_W-1);
    assign ready_o   = frame_end;

    // idle waits for the first frame, after that every boundary reloads
    assign start = frame_end && (state_q != dmix_pkg::TX_IDLE || valid_i);

    // one dead slot before each msb (i2s delay), zero padding after the lsb
    always_comb begin
        load_word = '0;
        if (valid_i) begin
            load_word = {1'b0, frame_i.left,
                         {(dmix_pkg::SLOT_W-dmix_pkg::SAMPLE_W-1){1'b0}},
                         1'b0, frame_i.right,
                         {(dmix_pkg::SLOT_W-dmix_pkg::SAMPLE_W-1){1'b0}}};
        end
    end

    always_ff @(posedge clk245760) begin
        if (!rst_n_i) begin
            div_q      <= '0;
            bit_q      <= '1;
            shift_q    <= '0;
            state_q    <= dmix_pkg::TX_IDLE;
            bck_q      <= 1'b0;
            lrck_q     <= 1'b0;
            data_q     <= 1'b0;
            underrun_q <= 1'b0;
        end else begin
            div_q <= bit_end ? '0 : div_q + 1'b1;
            if (bit_end) begin
                bck_q <= 1'b0;  // falling edge, data moves here
                if (start) begin
                    shift_q <= load_word << 1;
                    data_q  <= load_word[2*dmix_pkg::SLOT_W-1];
                    bit_q   <= '0;
                    lrck_q  <= 1'b0;
                    state_q <= dmix_pkg::TX_LEFT;
                    if (!valid_i) begin
                        underrun_q <= 1'b1;     // zeros go out, sticky
                    end
                end else if (state_q != dmix_pkg::TX_IDLE) begin
                    shift_q <= shift_q << 1;
                    data_q  <= shift_q[2*dmix_pkg::SLOT_W-1];
                    bit_q   <= bit_q + 1'b1;
                    if (bit_q == dmix_pkg::SLOT_W-1) begin
                        lrck_q  <= 1'b1;
                        state_q <= dmix_pkg::TX_RIGHT;
                    end
                end
            end else if (div_q == dmix_pkg::BCK_HALF-1 &&
                         state_q != dmix_pkg::TX_IDLE) begin
                bck_q <= 1'b1;  // dac samples here
            end
        end
    end

    assign dac_bck_o  = bck_q;
    assign dac_lrck_o = lrck_q;
    assign dac_data_o = data_q;
    assign underrun_o = underrun_q;

endmodule

// ==== dmix_top.sv ====
`timescale 1ns/1ps

module dmix_top (
    input  logic                                     clk245760,
    input  logic                                     rst_n_i,
    input  dmix_pkg::tagged_frame_t                  in_frame_i,
    input  logic                                     in_valid_i,
    output logic                                     in_ready_o,
    input  dmix_pkg::vol_t [dmix_pkg::NUM_LANES-1:0] vol_i,
    output logic                                     dac_bck_o,
    output logic                                     dac_lrck_o,
    output logic                                     dac_data_o,
    output logic                                     underrun_o,
    output logic                                     bad_tag_o
);

    dmix_pkg::stereo_t                           route_frame;   // shared by all lanes
    logic [dmix_pkg::NUM_LANES-1:0]              route_valid;
    logic [dmix_pkg::NUM_LANES-1:0]              route_ready;
    dmix_pkg::stereo_t [dmix_pkg::NUM_LANES-1:0] lane_frame;
    logic [dmix_pkg::NUM_LANES-1:0]              lane_valid;
    logic                                        lane_ready;
    dmix_pkg::stereo_t                           mix_frame;
    logic                                        mix_valid;
    logic                                        mix_ready;

    dmix_in_router i_router (
        .clk245760    (clk245760),
        .rst_n_i      (rst_n_i),
        .in_frame_i   (in_frame_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .lane_frame_o (route_frame),
        .lane_valid_o (route_valid),
        .lane_ready_i (route_ready),
        .bad_tag_o    (bad_tag_o)
    );

    for (genvar i = 0; i < dmix_pkg::NUM_LANES; i++) begin : g_lane
        dmix_lane i_lane (
            .clk245760   (clk245760),
            .rst_n_i     (rst_n_i),
            .vol_i       (vol_i[i]),
            .in_frame_i  (route_frame),
            .in_valid_i  (route_valid[i]),
            .in_ready_o  (route_ready[i]),
            .out_frame_o (lane_frame[i]),
            .out_valid_o (lane_valid[i]),
            .out_ready_i (lane_ready)   // common join strobe
        );
    end

    dmix_mixer i_mixer (
        .clk245760    (clk245760),
        .rst_n_i      (rst_n_i),
        .lane_frame_i (lane_frame),
        .lane_valid_i (lane_valid),
        .lane_ready_o (lane_ready),
        .mix_frame_o  (mix_frame),
        .mix_valid_o  (mix_valid),
        .mix_ready_i  (mix_ready)
    );

    dmix_i2s_tx i_tx (
        .clk245760  (clk245760),
        .rst_n_i    (rst_n_i),
        .frame_i    (mix_frame),
        .valid_i    (mix_valid),
        .ready_o    (mix_ready),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o),
        .underrun_o (underrun_o)
    );

endmodule

// ==== dmix_properties.sv ====
`timescale 1ns/1ps

module dmix_properties (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              in_valid_i,
    input logic              in_ready_i,
    input logic [49:0]       in_frame_i,
    input logic              mix_valid_i,
    input logic              mix_ready_i,
    input dmix_pkg::stereo_t mix_frame_i,
    input logic              dac_bck_i,
    input logic              dac_lrck_i,
    input logic              dac_data_i
);

    int   bck_cnt;  // bck rises since the last lrck edge
    logic bck_d;
    logic lrck_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bck_cnt <= 0;
            bck_d   <= 1'b0;
            lrck_d  <= 1'b0;
        end else begin
            bck_d  <= dac_bck_i;
            lrck_d <= dac_lrck_i;
            if (dac_lrck_i != lrck_d) bck_cnt <= 0;
            else if (dac_bck_i && !bck_d) bck_cnt <= bck_cnt + 1;
        end
    end

    a_in_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_frame_i))
        else $error("input frame changed while stalled");

    a_mix_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mix_valid_i && !mix_ready_i |=> mix_valid_i && $stable(mix_frame_i))
        else $error("mixer output changed while stalled");

    a_dac_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !dac_bck_i && !dac_lrck_i && !dac_data_i)
        else $error("dac pins not low in reset");

    a_lrck_period: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dac_lrck_i != lrck_d |-> bck_cnt == 32)
        else $error("lrck edge not after 32 bit clocks");

endmodule

bind dmix_top dmix_properties i_props (
    .clk_i       (clk245760),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .in_frame_i  (in_frame_i),
    .mix_valid_i (mix_valid),
    .mix_ready_i (mix_ready),
    .mix_frame_i (mix_frame),
    .dac_bck_i   (dac_bck_o),
    .dac_lrck_i  (dac_lrck_o),
    .dac_data_i  (dac_data_o)
);

// ==== tb_dmix_top.sv ====
`timescale 1ns/1ps

module tb_dmix_top;

    localparam int TOTAL_ROUNDS = 26;
    localparam int CYCLE_LIMIT  = (TOTAL_ROUNDS + 8) * 256 + 2000;  // gaps and tail words included

    typedef dmix_pkg::stereo_t [dmix_pkg::NUM_LANES-1:0] round_t;
    typedef dmix_pkg::vol_t [dmix_pkg::NUM_LANES-1:0]    vols_t;

    logic                    clk245760 = 1'b0;
    logic                    rst_n_i;
    dmix_pkg::tagged_frame_t in_frame_i;
    logic                    in_valid_i;
    logic                    in_ready_o;
    vols_t                   vol_i;
    logic                    dac_bck_o;
    logic                    dac_lrck_o;
    logic                    dac_data_o;
    logic                    underrun_o;
    logic                    bad_tag_o;

    logic [31:0]       lfsr_q = 32'ha327_9641;
    dmix_pkg::stereo_t exp_q[$];
    dmix_pkg::stereo_t cap_q[$];
    bit                resync = 1'b0;   // skip idle words before a new batch
    int                n_words = 0;
    int                n_errors = 0;
    int                cycles = 0;

    dmix_top i_dut (.*);

    always #10 clk245760 = ~clk245760;

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // expected mix from the scale and clamp rules
    function automatic dmix_pkg::stereo_t ref_mix(input round_t r, input vols_t v);
        longint sl;
        longint sr;
        dmix_pkg::stereo_t m;
        sl = 0;
        sr = 0;
        for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
            sl += (longint'(r[i].left) * longint'(v[i])) >>> 16;
            sr += (longint'(r[i].right) * longint'(v[i])) >>> 16;
        end
        m.left  = sl > 8388607 ? 24'h7fffff : sl < -8388608 ? 24'h800000 : sl[23:0];
        m.right = sr > 8388607 ? 24'h7fffff : sr < -8388608 ? 24'h800000 : sr[23:0];
        return m;
    endfunction

    task automatic check_frame(input string name, input dmix_pkg::stereo_t got,
                               input dmix_pkg::stereo_t exp);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic send_frame(input dmix_pkg::tagged_frame_t f);
        in_frame_i = f;
        in_valid_i = 1'b1;
        @(negedge clk245760);
        while (!in_ready_o) @(negedge clk245760);
        @(posedge clk245760);
        #2;
        in_valid_i = 1'b0;
    endtask

    // one frame per tag, shuffled
    task automatic send_round(input round_t r);
        int order[dmix_pkg::NUM_LANES];
        int j;
        int t;
        exp_q.push_back(ref_mix(r, vol_i));
        for (int i = 0; i < dmix_pkg::NUM_LANES; i++) order[i] = i;
        for (int i = dmix_pkg::NUM_LANES - 1; i > 0; i--) begin
            j = rand_bits(2) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
            send_frame({dmix_pkg::LANE_W'(order[i]), r[order[i]]});
        end
    endtask

    task automatic wait_drain();
        wait (exp_q.size() == 0);
        @(negedge clk245760);
    endtask

    // rebuild words from the serial line, slot 0 is the i2s dead bit
    initial begin
        logic [63:0] word;
        int          slot;
        slot = 0;
        forever begin
            @(posedge dac_bck_o);
            check_flag("dac_lrck_o", dac_lrck_o, slot >= 32);
            word = {word[62:0], dac_data_o};
            if (slot == 63) cap_q.push_back({word[62:39], word[30:7]});
            slot = (slot + 1) % 64;
        end
    end

    always @(posedge clk245760) begin
        dmix_pkg::stereo_t w;
        while (cap_q.size() > 0) begin
            w = cap_q.pop_front();
            n_words++;
            if (resync && w == '0) continue;
            resync = 1'b0;
            if (exp_q.size() == 0) check_frame("idle word", w, '0);
            else check_frame("mix word", w, exp_q.pop_front());
        end
    end

    always @(posedge clk245760) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the DUT stopped producing I2S words");
            $display("test failed");
            $fatal(1);
        end
    end

    initial begin
        round_t r;
        int     n0;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_frame_i = '0;
        vol_i      = {dmix_pkg::NUM_LANES{16'hffff}};
        repeat (5) @(posedge clk245760);
        #2;
        rst_n_i = 1'b1;
        check_flag("in_ready_o", in_ready_o, 1'b0);   // first cycle out of reset
        // full gain, random and saturating rounds sent as one burst
        for (int n = 0; n < 6; n++) begin
            for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
                r[i].left  = rand_bits(24);
                r[i].right = rand_bits(24);
            end
            send_round(r);
        end
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
                r[i].left  = (n[0] ? 24'h800000 : 24'h700000) | rand_bits(20);
                r[i].right = (n[0] ? 24'h700000 : 24'h800000) | rand_bits(20);
            end
            send_round(r);
        end
        wait_drain();
        check_flag("underrun_o", underrun_o, 1'b0);
        // one lane live, the others muted
        for (int lane = 0; lane < dmix_pkg::NUM_LANES; lane++) begin
            wait_drain();
            @(posedge clk245760);
            #2;
            vol_i       = '0;
            vol_i[lane] = rand_bits(16) | 16'h8000;
            resync      = 1'b1;
            for (int n = 0; n < 4; n++) begin
                for (int i = 0; i < dmix_pkg::NUM_LANES; i++) begin
                    r[i].left  = rand_bits(24);
                    r[i].right = rand_bits(24);
                    r[i].left[22] = ~r[i].left[23];     // keeps the word nonzero
                end
                send_round(r);
            end
        end
        wait_drain();
        n0 = n_words;
        wait (n_words >= n0 + 3);
        @(negedge clk245760);
        check_flag("underrun_o", underrun_o, 1'b1);
        check_flag("bad_tag_o", bad_tag_o, 1'b0);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
dmix_pkg.sv
dmix_in_router.sv
dmix_lane.sv
dmix_mixer.sv
dmix_i2s_tx.sv
dmix_top.sv
dmix_properties.sv
tb_dmix_top.sv
